//--- source/uart_pkg.sv
package uart_pkg;

    // receive lanes and lane number width.
    localparam int num_ch = 4;
    localparam int ch_w = 2;

    // fixed serial timing, derived from the system clock.
    localparam int clk_per_sec = 1_843_200;
    localparam int baud = 115_200;
    localparam int clk_per_bit = clk_per_sec / baud;
    localparam int clk_per_half_bit = clk_per_bit / 2;
    // stop bit is sampled early so a back to back start edge is never missed.
    localparam int clk_per_stop_sample = clk_per_bit - clk_per_bit / 4;

    // samples that must agree before a lane counts as stable.
    localparam int filter_depth = 5;

    localparam int bit_cnt_w = $clog2(clk_per_bit);

    typedef logic [7:0] byte_t;
    typedef logic [ch_w-1:0] ch_id_t;
    typedef logic [bit_cnt_w-1:0] bit_cnt_t;

    // last count value of each bit timing window.
    localparam bit_cnt_t half_bit_last = bit_cnt_t'(clk_per_half_bit - 1);
    localparam bit_cnt_t bit_last = bit_cnt_t'(clk_per_bit - 1);
    localparam bit_cnt_t stop_sample_last = bit_cnt_t'(clk_per_stop_sample - 1);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_req_high,
        arb_wait_ack_low
    } arb_state_e;

endpackage

//--- source/rx_byte_if.sv
`timescale 1ns/10ps

interface rx_byte_if;

    logic            byte_valid;
    uart_pkg::byte_t byte_data;
    logic            overrun;
    // one cycle pulse, the channel frees its slot on it.
    logic            byte_taken;

    modport channel (
        output byte_valid,
        output byte_data,
        output overrun,
        input  byte_taken
    );

    modport arbiter (
        input  byte_valid,
        input  byte_data,
        input  overrun,
        output byte_taken
    );

endinterface

//--- source/rx_line_filter.sv
`timescale 1ns/10ps

module rx_line_filter (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [uart_pkg::num_ch-1:0] rxd,
    output logic [uart_pkg::num_ch-1:0] line,
    output logic [uart_pkg::num_ch-1:0] stable
);

    // per lane sample history, newest sample in bit 0.
    logic [uart_pkg::filter_depth-1:0] hist_q [uart_pkg::num_ch];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int ch = 0; ch < uart_pkg::num_ch; ch++) begin
                hist_q[ch] <= '1;
            end
            stable <= '1;
        end else begin
            for (int ch = 0; ch < uart_pkg::num_ch; ch++) begin
                hist_q[ch] <= {hist_q[ch][uart_pkg::filter_depth-2:0], rxd[ch]};
                // all stages equal, either level.
                stable[ch] <= (&hist_q[ch]) || (~|hist_q[ch]);
            end
        end
    end

    // oldest stage is the sample the receivers use.
    always_comb begin
        for (int ch = 0; ch < uart_pkg::num_ch; ch++) begin
            line[ch] = hist_q[ch][uart_pkg::filter_depth-1];
        end
    end

endmodule

//--- source/uart_rx_channel.sv
`timescale 1ns/10ps

module uart_rx_channel (
    input  logic       clk,
    input  logic       rstn,
    input  logic       line,
    input  logic       stable,
    rx_byte_if.channel byte_if
);

    uart_pkg::rx_state_e state;
    uart_pkg::rx_state_e state_next;
    uart_pkg::bit_cnt_t  bit_cnt;
    logic [2:0]          bit_idx;
    uart_pkg::byte_t     shift_q;

    logic half_mark;
    logic bit_mark;
    logic stop_mark;
    logic sample_due;
    logic sample_ok;
    logic frame_ok;
    logic slot_full;

    // timing marks from the bit counter.
    assign half_mark = (bit_cnt == uart_pkg::half_bit_last);
    assign bit_mark = (bit_cnt == uart_pkg::bit_last);
    assign stop_mark = (bit_cnt == uart_pkg::stop_sample_last);

    assign sample_due = ((state == uart_pkg::rx_data) && bit_mark) ||
                        ((state == uart_pkg::rx_stop) && stop_mark);
    assign sample_ok = sample_due && stable;

    // good stop bit seen.
    assign frame_ok = (state == uart_pkg::rx_stop) && sample_ok && line;

    // a slot freed in this very cycle can take the new byte.
    assign slot_full = byte_if.byte_valid && !byte_if.byte_taken;

    always_comb begin
        state_next = state;
        case (state)
            uart_pkg::rx_idle: begin
                if (stable && !line) begin
                    state_next = uart_pkg::rx_start;
                end
            end
            uart_pkg::rx_start: begin
                if (half_mark) begin
                    state_next = uart_pkg::rx_data;
                end
            end
            uart_pkg::rx_data: begin
                if (sample_ok && (bit_idx == 3'd7)) begin
                    state_next = uart_pkg::rx_stop;
                end
            end
            uart_pkg::rx_stop: begin
                if (sample_ok) begin
                    state_next = uart_pkg::rx_idle;
                end
            end
            default: begin
                state_next = uart_pkg::rx_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bit_cnt <= '0;
        end else if (state_next != state) begin
            bit_cnt <= '0;
        end else if (sample_due && !stable) begin
            // wait on the sample point until the line settles.
            bit_cnt <= bit_cnt;
        end else if (bit_mark) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + uart_pkg::bit_cnt_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= uart_pkg::rx_idle;
            bit_idx <= '0;
            byte_if.byte_valid <= 1'b0;
            byte_if.overrun <= 1'b0;
        end else begin
            state <= state_next;

            if (state == uart_pkg::rx_start) begin
                bit_idx <= '0;
            end else if ((state == uart_pkg::rx_data) && sample_ok) begin
                bit_idx <= bit_idx + 3'd1;
            end

            if (frame_ok) begin
                if (slot_full) begin
                    // new frame is lost, mark the held one.
                    byte_if.overrun <= 1'b1;
                end else begin
                    byte_if.byte_valid <= 1'b1;
                    byte_if.overrun <= 1'b0;
                end
            end else if (byte_if.byte_taken) begin
                byte_if.byte_valid <= 1'b0;
                byte_if.overrun <= 1'b0;
            end
        end
    end

    // data bits arrive lsb first.
    always_ff @(posedge clk) begin
        if ((state == uart_pkg::rx_data) && sample_ok) begin
            shift_q <= {line, shift_q[7:1]};
        end
        if (frame_ok && !slot_full) begin
            byte_if.byte_data <= shift_q;
        end
    end

endmodule

//--- source/rx_byte_arbiter.sv
`timescale 1ns/10ps

module rx_byte_arbiter (
    input  logic              clk,
    input  logic              rstn,
    input  logic              out_ack,
    rx_byte_if.arbiter        lanes [uart_pkg::num_ch],
    output logic              out_req,
    output uart_pkg::ch_id_t  out_channel,
    output uart_pkg::byte_t   out_data,
    output logic              out_overrun
);

    uart_pkg::arb_state_e state;
    uart_pkg::ch_id_t     last_ch;
    uart_pkg::ch_id_t     pick;
    uart_pkg::ch_id_t     idx;
    logic                 found;

    logic [uart_pkg::num_ch-1:0] valid_vec;
    logic [uart_pkg::num_ch-1:0] overrun_vec;
    logic [uart_pkg::num_ch-1:0] taken_q;
    uart_pkg::byte_t             data_arr [uart_pkg::num_ch];

    for (genvar i = 0; i < uart_pkg::num_ch; i++) begin : g_lane
        assign valid_vec[i] = lanes[i].byte_valid;
        assign overrun_vec[i] = lanes[i].overrun;
        assign data_arr[i] = lanes[i].byte_data;
        assign lanes[i].byte_taken = taken_q[i];
    end

    // round robin, the search starts one past the last lane served.
    always_comb begin
        found = 1'b0;
        pick = last_ch;
        idx = last_ch;
        for (int k = 1; k <= uart_pkg::num_ch; k++) begin
            idx = last_ch + uart_pkg::ch_id_t'(k);
            if (!found && valid_vec[idx]) begin
                found = 1'b1;
                pick = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= uart_pkg::arb_idle;
            last_ch <= uart_pkg::ch_id_t'(uart_pkg::num_ch - 1);
            taken_q <= '0;
        end else begin
            taken_q <= '0;
            case (state)
                uart_pkg::arb_idle: begin
                    if (found) begin
                        state <= uart_pkg::arb_req_high;
                        last_ch <= pick;
                        taken_q[pick] <= 1'b1;
                    end
                end
                uart_pkg::arb_req_high: begin
                    if (out_ack) begin
                        state <= uart_pkg::arb_wait_ack_low;
                    end
                end
                uart_pkg::arb_wait_ack_low: begin
                    if (!out_ack) begin
                        state <= uart_pkg::arb_idle;
                    end
                end
                default: begin
                    state <= uart_pkg::arb_idle;
                end
            endcase
        end
    end

    // outputs load with the take and hold until the handshake ends.
    always_ff @(posedge clk) begin
        if ((state == uart_pkg::arb_idle) && found) begin
            out_channel <= pick;
            out_data <= data_arr[pick];
            out_overrun <= overrun_vec[pick];
        end
    end

    assign out_req = (state == uart_pkg::arb_req_high);

endmodule

//--- source/uart_rx_hub.sv
`timescale 1ns/10ps

module uart_rx_hub (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [uart_pkg::num_ch-1:0] rxd,
    input  logic                        out_ack,
    output logic                        out_req,
    output uart_pkg::ch_id_t            out_channel,
    output uart_pkg::byte_t             out_data,
    output logic                        out_overrun
);

    logic [uart_pkg::num_ch-1:0] line;
    logic [uart_pkg::num_ch-1:0] stable;

    // one byte slot link per lane.
    rx_byte_if byte_if [uart_pkg::num_ch] ();

    rx_line_filter rx_line_filter_i (
        .clk    (clk),
        .rstn   (rstn),
        .rxd    (rxd),
        .line   (line),
        .stable (stable)
    );

    for (genvar i = 0; i < uart_pkg::num_ch; i++) begin : g_ch
        uart_rx_channel uart_rx_channel_i (
            .clk     (clk),
            .rstn    (rstn),
            .line    (line[i]),
            .stable  (stable[i]),
            .byte_if (byte_if[i])
        );
    end

    rx_byte_arbiter rx_byte_arbiter_i (
        .clk         (clk),
        .rstn        (rstn),
        .out_ack     (out_ack),
        .lanes       (byte_if),
        .out_req     (out_req),
        .out_channel (out_channel),
        .out_data    (out_data),
        .out_overrun (out_overrun)
    );

endmodule

//--- bench/tb_uart_rx_hub.sv
`timescale 1ns/10ps

module tb_uart_rx_hub;

    localparam int bit_clks = 16;
    localparam int frame_clks = 10 * bit_clks;
    localparam int req_timeout = 4 * frame_clks;
    localparam int ack_timeout = 64;

    logic                        clk;
    logic                        rstn;
    logic [uart_pkg::num_ch-1:0] rxd;
    logic                        out_ack;
    logic                        out_req;
    uart_pkg::ch_id_t            out_channel;
    uart_pkg::byte_t             out_data;
    logic                        out_overrun;

    int          checks;
    int          errors;
    logic [31:0] lfsr_q;

    uart_rx_hub uart_rx_hub_i (
        .clk         (clk),
        .rstn        (rstn),
        .rxd         (rxd),
        .out_ack     (out_ack),
        .out_req     (out_req),
        .out_channel (out_channel),
        .out_data    (out_data),
        .out_overrun (out_overrun)
    );

    always #4 clk = ~clk;

    // inputs change and outputs are read just after the rising edge.
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_data(input uart_pkg::byte_t got, input uart_pkg::byte_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_channel(input uart_pkg::ch_id_t got, input uart_pkg::ch_id_t exp,
                                 input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got lane %0d, expected lane %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_overrun(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got overrun %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_req(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, out_req seen %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = {val[6:0], lfsr_q[0]};
        end
    endtask

    // one frame on every lane set in mask, data bits go lsb first.
    task automatic send_frames(input logic [uart_pkg::num_ch-1:0] mask,
                               input uart_pkg::byte_t data [uart_pkg::num_ch],
                               input logic stop_level);
        logic [uart_pkg::num_ch-1:0] level;
        for (int b = 0; b < 10; b++) begin
            for (int ch = 0; ch < uart_pkg::num_ch; ch++) begin
                if (b == 0) begin
                    level[ch] = 1'b0;
                end else if (b == 9) begin
                    level[ch] = stop_level;
                end else begin
                    level[ch] = data[ch][b-1];
                end
            end
            rxd = (rxd & ~mask) | (level & mask);
            if ((b == 9) && !stop_level) begin
                // low through the settled stop sample and high again before the receiver rearms.
                repeat (bit_clks / 2 + 1) tick();
                rxd = rxd | mask;
                repeat (bit_clks / 2 - 1) tick();
            end else begin
                repeat (bit_clks) tick();
            end
        end
    endtask

    task automatic send_byte(input int lane, input uart_pkg::byte_t data, input logic stop_level);
        uart_pkg::byte_t             bytes [uart_pkg::num_ch];
        logic [uart_pkg::num_ch-1:0] mask;
        mask = '0;
        mask[lane] = 1'b1;
        bytes = '{default: data};
        send_frames(mask, bytes, stop_level);
    endtask

    // host side of the four-phase handshake with ack held back by ack_delay clocks.
    task automatic receive_byte(input int ack_delay, output uart_pkg::ch_id_t ch,
                                output uart_pkg::byte_t data, output logic ovr, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!out_req && (n < req_timeout)) begin
            tick();
            n++;
        end
        if (!out_req) begin
            errors++;
            $display("timeout at %0t: out_req never rose", $time);
            return;
        end
        ch = out_channel;
        data = out_data;
        ovr = out_overrun;
        repeat (ack_delay) tick();
        out_ack = 1'b1;
        n = 0;
        while (out_req && (n < ack_timeout)) begin
            tick();
            n++;
        end
        out_ack = 1'b0;
        if (out_req) begin
            errors++;
            $display("timeout at %0t: out_req stayed high after ack", $time);
            return;
        end
        ok = 1'b1;
    endtask

    task automatic expect_quiet(input int clks, input string what);
        logic seen_req;
        seen_req = 1'b0;
        for (int n = 0; n < clks; n++) begin
            tick();
            if (out_req) begin
                seen_req = 1'b1;
            end
        end
        check_req(seen_req, 1'b0, what);
    endtask

    task automatic end_test(input string name, input int errors_before);
        $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    task automatic single_byte_delivery();
        int               e0;
        uart_pkg::ch_id_t ch;
        uart_pkg::byte_t  data;
        logic             ovr;
        bit               ok;
        e0 = errors;
        send_byte(1, 8'hA5, 1'b1);
        receive_byte(0, ch, data, ovr, ok);
        if (ok) begin
            check_channel(ch, 2'd1, "single byte lane");
            check_data(data, 8'hA5, "single byte data");
            check_overrun(ovr, 1'b0, "single byte overrun");
        end
        end_test("single_byte", e0);
    endtask

    task automatic all_lanes_at_once();
        int               e0;
        int               seen [uart_pkg::num_ch];
        uart_pkg::byte_t  bytes [uart_pkg::num_ch];
        uart_pkg::ch_id_t ch;
        uart_pkg::byte_t  data;
        logic             ovr;
        bit               ok;
        e0 = errors;
        seen = '{default: 0};
        bytes = '{8'h3E, 8'h81, 8'hC4, 8'h07};
        send_frames('1, bytes, 1'b1);
        for (int i = 0; i < uart_pkg::num_ch; i++) begin
            receive_byte(0, ch, data, ovr, ok);
            if (ok) begin
                seen[ch]++;
                check_data(data, bytes[ch], "all lanes data");
                check_overrun(ovr, 1'b0, "all lanes overrun");
            end
        end
        for (int i = 0; i < uart_pkg::num_ch; i++) begin
            check_count(seen[i], 1, "deliveries per lane");
        end
        end_test("all_lanes", e0);
    endtask

    task automatic framing_error_drop();
        int               e0;
        uart_pkg::ch_id_t ch;
        uart_pkg::byte_t  data;
        logic             ovr;
        bit               ok;
        e0 = errors;
        send_byte(2, 8'h3C, 1'b0);
        expect_quiet(2 * frame_clks, "frame with low stop bit");
        send_byte(2, 8'h5A, 1'b1);
        receive_byte(0, ch, data, ovr, ok);
        if (ok) begin
            check_channel(ch, 2'd2, "frame after error lane");
            check_data(data, 8'h5A, "frame after error data");
            check_overrun(ovr, 1'b0, "frame after error overrun");
        end
        end_test("framing_error", e0);
    endtask

    task automatic glitch_rejection();
        int e0;
        e0 = errors;
        rxd[3] = 1'b0;
        repeat (uart_pkg::filter_depth - 1) tick();
        rxd[3] = 1'b1;
        expect_quiet(2 * frame_clks, "short low pulse");
        end_test("glitch", e0);
    endtask

    task automatic overrun_on_full_slot();
        int               e0;
        uart_pkg::ch_id_t ch;
        uart_pkg::byte_t  data;
        logic             ovr;
        bit               ok;
        e0 = errors;
        fork
            begin
                send_byte(0, 8'h11, 1'b1);
                send_byte(0, 8'h22, 1'b1);
                send_byte(0, 8'h33, 1'b1);
            end
            // ack comes only after the third frame has finished.
            receive_byte(25 * bit_clks, ch, data, ovr, ok);
        join
        if (ok) begin
            check_data(data, 8'h11, "first held byte");
            check_overrun(ovr, 1'b0, "first held byte overrun");
        end
        receive_byte(0, ch, data, ovr, ok);
        if (ok) begin
            check_data(data, 8'h22, "second held byte");
            check_overrun(ovr, 1'b1, "second held byte overrun");
        end
        expect_quiet(2 * frame_clks, "lost third byte");
        end_test("overrun", e0);
    endtask

    task automatic random_traffic();
        int               e0;
        logic [7:0]       rnd;
        uart_pkg::ch_id_t lane;
        uart_pkg::ch_id_t ch;
        uart_pkg::byte_t  data;
        logic             ovr;
        bit               ok;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            take_bits(2, rnd);
            lane = uart_pkg::ch_id_t'(rnd);
            take_bits(8, rnd);
            send_byte(int'(lane), rnd, 1'b1);
            receive_byte(int'(lane), ch, data, ovr, ok);
            if (ok) begin
                check_channel(ch, lane, "random lane");
                check_data(data, rnd, "random data");
                check_overrun(ovr, 1'b0, "random overrun");
            end
        end
        end_test("random", e0);
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        rxd = '1;
        out_ack = 1'b0;
        checks = 0;
        errors = 0;
        lfsr_q = 32'd96240;
        repeat (2) tick();
        rstn = 1'b1;
        repeat (4) tick();

        single_byte_delivery();
        all_lanes_at_once();
        framing_error_drop();
        glitch_rejection();
        overrun_on_full_slot();
        random_traffic();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/uart_pkg.sv
source/rx_byte_if.sv
source/rx_line_filter.sv
source/uart_rx_channel.sv
source/rx_byte_arbiter.sv
source/uart_rx_hub.sv
bench/tb_uart_rx_hub.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps --top-module tb_uart_rx_hub \
    -f vlog.f -o sim_uart_rx_hub > build.log 2>&1 \
    && ./obj_dir/sim_uart_rx_hub > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
